// File: serial_pkg.sv
/*
 * shared definitions for the 3-wire serial master
 * word format, serial clock divider, idle levels, init word table, state enums
 */
package serial_pkg;

	// ------------------------------------------------------------------------
	// word format
	// ------------------------------------------------------------------------
	localparam int unsigned word_bits = 8;
	localparam int unsigned bit_idx_bits = $clog2(word_bits);
	localparam logic [bit_idx_bits-1:0] bit_last = bit_idx_bits'(word_bits - 1);
	// low bit goes out first
	localparam logic lowbit_first = 1'b1;

	typedef logic [word_bits-1:0] word_t;

	// ------------------------------------------------------------------------
	// serial clock
	// ------------------------------------------------------------------------
	// serial_clk cycles per half bit
	localparam int unsigned clk_div = 4;
	localparam int unsigned div_bits = $clog2(clk_div);
	localparam logic [div_bits-1:0] div_last = div_bits'(clk_div - 1);
	// one cycle before the end of a half bit
	localparam logic [div_bits-1:0] div_pre = div_bits'(clk_div - 2);

	// line levels while nothing is sent
	localparam logic sclk_idle = 1'b1;
	localparam logic sdo_idle = 1'b1;

	// ------------------------------------------------------------------------
	// configuration words sent once after reset, index 0 first
	// ------------------------------------------------------------------------
	localparam int unsigned init_words = 4;
	localparam int unsigned init_idx_bits = $clog2(init_words);
	localparam logic [init_idx_bits-1:0] init_last = init_idx_bits'(init_words - 1);
	localparam word_t init_table [init_words] = '{8'h3c, 8'h81, 8'ha5, 8'h0f};

	// state and owner encodings
	typedef enum logic {st_idle, st_shift} shift_state_t;
	typedef enum logic [1:0] {own_none, own_init, own_host} owner_t;
	typedef enum logic [1:0] {st_wait, st_send, st_done} init_state_t;

endpackage

// File: serial_bus_if.sv
/*
 * shifter port shared by the arbiter and the shifter
 * owner and shifter modports
 */
`timescale 1ns/1ps

interface serial_bus_if;
	import serial_pkg::*;

	// level, held high while the owner wants words
	logic enable;
	// next word to send, latched at word start
	word_t tx_word;
	// shifter idle
	logic ready;
	// one cycle before word_done
	logic next_word;
	// last cycle of a word
	logic word_done;
	// received word, valid at word_done
	word_t rx_word;

	modport owner (
		output enable, tx_word,
		input ready, next_word, word_done, rx_word
	);

	modport shifter (
		input enable, tx_word,
		output ready, next_word, word_done, rx_word
	);

endinterface

// File: serial_tick_gen.sv
/*
 * half bit divider for the serial clock
 * rise and fall phase strobes, realigned at word start
 */
`timescale 1ns/1ps

module serial_tick_gen (
	input logic serial_clk,
	input logic in_rst,
	input logic restart,
	output logic fall_tick,
	output logic rise_tick
);
	import serial_pkg::*;

	logic [div_bits-1:0] div_cnt;
	// set during the high half of a bit
	logic high_half;

	// low half starts in the cycle after restart
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			div_cnt <= '0;
			high_half <= 1'b0;
		end else if (restart) begin
			div_cnt <= '0;
			high_half <= 1'b0;
		end else if (div_cnt == div_last) begin
			div_cnt <= '0;
			high_half <= ~high_half;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// last low cycle, sclk rises at its end
	assign rise_tick = ~high_half && (div_cnt == div_last);
	// one cycle ahead of the fall, so the last-word warning can go out early
	assign fall_tick = high_half && (div_cnt == div_pre);

endmodule

// File: serial_shifter.sv
/*
 * serial shifter FSM with bit counter and tx/rx shift registers
 * gated serial clock, data out on the fall, data in sampled on the rise
 */
`timescale 1ns/1ps

module serial_shifter (
	input logic serial_clk,
	input logic in_rst,
	serial_bus_if.shifter bus,
	output logic sclk,
	output logic sdo,
	input logic sdi
);
	import serial_pkg::*;

	shift_state_t state;
	logic [bit_idx_bits-1:0] bit_cnt;
	// bit position in the word after order handling
	logic [bit_idx_bits-1:0] bit_idx;
	logic last_bit;
	logic sclk_q;
	// last high cycle of a bit
	logic bit_end;
	logic start;
	logic fall_tick;
	logic rise_tick;
	word_t tx_q;
	word_t rx_q;
	word_t rx_next;

	serial_tick_gen tick_gen_i (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.restart(start),
		.fall_tick(fall_tick),
		.rise_tick(rise_tick)
	);

	// ------------------------------------------------------------------------
	// bit order and word framing
	// ------------------------------------------------------------------------
	assign bit_idx = lowbit_first ? bit_cnt : bit_last - bit_cnt;
	assign last_bit = (bit_cnt == bit_last);

	assign bus.ready = (state == st_idle);
	assign bus.next_word = (state == st_shift) && last_bit && fall_tick;
	assign bus.word_done = (state == st_shift) && last_bit && bit_end;

	// new word from idle, or straight after the current one
	assign start = bus.enable && ((state == st_idle) || bus.word_done);

	// ------------------------------------------------------------------------
	// FSM, bit counter and serial clock level
	// ------------------------------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= st_idle;
			bit_cnt <= '0;
			sclk_q <= sclk_idle;
			bit_end <= 1'b0;
		end else begin
			bit_end <= (state == st_shift) && fall_tick;
			if (start) begin
				// first bit goes out with the falling edge
				state <= st_shift;
				bit_cnt <= '0;
				sclk_q <= 1'b0;
			end else if (state == st_shift) begin
				if (rise_tick) begin
					sclk_q <= 1'b1;
				end
				if (bit_end) begin
					sclk_q <= 1'b0;
					if (last_bit) begin
						state <= st_idle;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// tx and rx data
	// ------------------------------------------------------------------------
	always_comb begin
		rx_next = rx_q;
		rx_next[bit_idx] = sdi;
	end

	always_ff @(posedge serial_clk) begin
		if (start) begin
			tx_q <= bus.tx_word;
		end
		// sample on the rise, the last sample completes the word
		if ((state == st_shift) && rise_tick) begin
			rx_q <= rx_next;
			if (last_bit) begin
				bus.rx_word <= rx_next;
			end
		end
	end

	// clock and data held at idle levels outside a word
	assign sclk = (state == st_shift) ? sclk_q : sclk_idle;
	assign sdo = (state == st_shift) ? tx_q[bit_idx] : sdo_idle;

endmodule

// File: serial_arbiter.sv
/*
 * arbiter for the shared shifter, init sequencer over host
 * grant held for a whole burst, strobes routed to the owner only
 */
`timescale 1ns/1ps

module serial_arbiter (
	input logic serial_clk,
	input logic in_rst,
	input logic init_enable,
	input serial_pkg::word_t init_tx_word,
	output logic init_next_word,
	output logic init_word_done,
	input logic host_enable,
	input serial_pkg::word_t host_tx_word,
	output logic host_next_word,
	output logic host_word_done,
	output logic host_granted,
	output serial_pkg::word_t rx_word,
	output serial_pkg::owner_t owner,
	serial_bus_if.owner bus
);
	import serial_pkg::*;

	owner_t owner_next;
	// current owner still asks for words
	logic keep;

	assign keep = ((owner == own_init) && init_enable) ||
		((owner == own_host) && host_enable);

	// ownership moves only while the shifter is idle
	always_comb begin
		owner_next = owner;
		if (bus.ready && !keep) begin
			if (init_enable) begin
				owner_next = own_init;
			end else if (host_enable) begin
				owner_next = own_host;
			end else begin
				owner_next = own_none;
			end
		end
	end

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			owner <= own_none;
		end else begin
			owner <= owner_next;
		end
	end

	// request side from the owner
	always_comb begin
		case (owner)
			own_init: begin
				bus.enable = init_enable;
				bus.tx_word = init_tx_word;
			end
			own_host: begin
				bus.enable = host_enable;
				bus.tx_word = host_tx_word;
			end
			default: begin
				bus.enable = 1'b0;
				bus.tx_word = '0;
			end
		endcase
	end

	// strobes back to the owner, loser sees them low
	assign init_next_word = (owner == own_init) && bus.next_word;
	assign init_word_done = (owner == own_init) && bus.word_done;
	assign host_next_word = (owner == own_host) && bus.next_word;
	assign host_word_done = (owner == own_host) && bus.word_done;
	assign host_granted = (owner == own_host);

	// shared, qualified by the strobes
	assign rx_word = bus.rx_word;

endmodule

// File: init_sequencer.sv
/*
 * init sequencer, sends the package init table as one burst after reset
 * then flags init_done
 */
`timescale 1ns/1ps

module init_sequencer (
	input logic serial_clk,
	input logic in_rst,
	output logic enable,
	output serial_pkg::word_t tx_word,
	input logic next_word,
	input logic word_done,
	output logic init_done
);
	import serial_pkg::*;

	init_state_t state;
	logic [init_idx_bits-1:0] idx;
	// last table word already requested
	logic last_req;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= st_wait;
			idx <= '0;
			last_req <= 1'b0;
		end else begin
			case (state)
				// first cycle out of reset, the request is already up
				st_wait: begin
					state <= st_send;
				end
				st_send: begin
					// next word must sit on tx_word by the word_done cycle
					if (next_word) begin
						if (idx == init_last) begin
							last_req <= 1'b1;
						end else begin
							idx <= idx + 1'b1;
						end
					end
					if (word_done && last_req) begin
						state <= st_done;
					end
				end
				st_done: begin
					state <= st_done;
				end
				default: begin
					state <= st_wait;
				end
			endcase
		end
	end

	// request held from reset so the arbiter sees init before the host
	assign enable = (state != st_done) && !last_req;
	assign tx_word = init_table[idx];
	assign init_done = (state == st_done);

endmodule

// File: serial_top.sv
/*
 * top level of the 3-wire serial master
 * init sequencer and host port sharing one shifter through the arbiter
 */
`timescale 1ns/1ps

module serial_top (
	input logic serial_clk,
	input logic in_rst,
	input logic host_enable,
	input serial_pkg::word_t host_tx_word,
	output logic host_next_word,
	output logic host_word_done,
	output serial_pkg::word_t host_rx_word,
	output logic host_granted,
	output logic init_done,
	output logic sclk,
	output logic sdo,
	input logic sdi
);
	import serial_pkg::*;

	// init sequencer to arbiter
	logic init_enable;
	word_t init_tx_word;
	logic init_next_word;
	logic init_word_done;

	// arbiter to shifter
	serial_bus_if bus_i ();

	init_sequencer init_seq_i (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.enable(init_enable),
		.tx_word(init_tx_word),
		.next_word(init_next_word),
		.word_done(init_word_done),
		.init_done(init_done)
	);

	// owner is a debug view, not brought out here
	serial_arbiter arbiter_i (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.init_enable(init_enable),
		.init_tx_word(init_tx_word),
		.init_next_word(init_next_word),
		.init_word_done(init_word_done),
		.host_enable(host_enable),
		.host_tx_word(host_tx_word),
		.host_next_word(host_next_word),
		.host_word_done(host_word_done),
		.host_granted(host_granted),
		.rx_word(host_rx_word),
		.owner(),
		.bus(bus_i)
	);

	serial_shifter shifter_i (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.bus(bus_i),
		.sclk(sclk),
		.sdo(sdo),
		.sdi(sdi)
	);

endmodule

// File: tb_serial.sv
/*
 * testbench for the 3-wire serial master
 * clock, reset, echo slave on the serial lines, line monitor, directed tests
 */
`timescale 1ns/1ps

module tb_serial;
	import serial_pkg::*;

	localparam int word_cycles = 2 * word_bits * clk_div;
	localparam int word_limit = 2 * word_cycles;

	logic serial_clk;
	logic in_rst = 1'b1;
	logic host_enable;
	word_t host_tx_word;
	logic host_next_word;
	logic host_word_done;
	word_t host_rx_word;
	logic host_granted;
	logic init_done;
	logic sclk;
	logic sdo;
	logic sdi;

	int error_count = 0;
	int timeout_count = 0;
	integer seed;
	word_t burst_words [0:7];

	// line monitor state updated mid-cycle
	logic sclk_prev;
	word_t sdo_shift;
	int sdo_bits;
	word_t sdo_words [$];
	logic next_prev;
	int host_next_cnt;
	int host_done_cnt;
	int order_errors;
	int high_run;
	logic gap_arm = 1'b0;
	int gap_max;
	int gap_falls;
	logic len_open;
	int len_cnt;
	int len_q [$];
	logic granted_early;
	logic done_early;

	// echo slave returns the previous word
	word_t echo_sr = '0;

	serial_top serial_top_i (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.host_enable(host_enable),
		.host_tx_word(host_tx_word),
		.host_next_word(host_next_word),
		.host_word_done(host_word_done),
		.host_rx_word(host_rx_word),
		.host_granted(host_granted),
		.init_done(init_done),
		.sclk(sclk),
		.sdo(sdo),
		.sdi(sdi)
	);

	initial begin
		serial_clk = 1'b0;
		forever begin
			#2 serial_clk = ~serial_clk;
		end
	end

	// ------------------------------------------------------------------------
	// echo slave and line monitor
	// ------------------------------------------------------------------------
	always @(posedge sclk or posedge in_rst) begin
		if (in_rst) begin
			echo_sr <= '0;
		end else begin
			echo_sr <= {sdo, echo_sr[word_bits-1:1]};
		end
	end

	// bit leaving the register goes back to the master
	assign sdi = echo_sr[0];

	// one bit per sclk rise with the low bit first
	task automatic collect_sdo_bit;
		sdo_shift = {sdo, sdo_shift[word_bits-1:1]};
		sdo_bits++;
		if (sdo_bits == word_bits) begin
			sdo_words.push_back(sdo_shift);
			sdo_bits = 0;
		end
	endtask

	always @(negedge serial_clk) begin
		if (in_rst) begin
			sclk_prev = sclk_idle;
			sdo_bits = 0;
			next_prev = 1'b0;
			host_next_cnt = 0;
			host_done_cnt = 0;
			order_errors = 0;
			high_run = 0;
			gap_max = 0;
			gap_falls = 0;
			len_open = 1'b0;
			len_cnt = 0;
			granted_early = 1'b0;
			done_early = 1'b0;
		end else begin
			if (!sclk_prev && sclk) begin
				collect_sdo_bit();
			end
			// high time ahead of each fall while a burst runs
			if (sclk_prev && !sclk && gap_arm) begin
				gap_falls++;
				if (high_run > gap_max) begin
					gap_max = high_run;
				end
			end
			high_run = sclk ? high_run + 1 : 0;
			// word length from the first fall up to word_done
			if (len_open) begin
				len_cnt++;
			end
			if (sclk_prev && !sclk && !len_open && host_granted) begin
				len_open = 1'b1;
				len_cnt = 1;
			end
			if (host_next_word) begin
				host_next_cnt++;
			end
			if (host_word_done) begin
				host_done_cnt++;
				if (!next_prev) begin
					order_errors++;
				end
				if (len_open) begin
					len_q.push_back(len_cnt);
					len_open = 1'b0;
				end
			end
			next_prev = host_next_word;
			if (host_granted && !init_done) begin
				granted_early = 1'b1;
			end
			if (init_done && sdo_words.size() < init_words) begin
				done_early = 1'b1;
			end
			sclk_prev = sclk;
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic flag_error(input string msg);
		$display("[ERROR] t=%0t %s", $time, msg);
		error_count++;
	endtask

	task automatic note_timeout(input string what, input int limit);
		$display("timeout: %s within %0d cycles", what, limit);
		timeout_count++;
	endtask

	task automatic expect_idle_lines(input string when);
		if (sclk !== sclk_idle || sdo !== sdo_idle) begin
			flag_error($sformatf("lines not idle %s, sclk %b sdo %b", when, sclk, sdo));
		end
		if (host_granted !== 1'b0 || host_next_word !== 1'b0 || host_word_done !== 1'b0) begin
			flag_error($sformatf("host grant or strobes high %s", when));
		end
	endtask

	task automatic wait_for_grant(input logic level);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < word_limit) begin
			@(negedge serial_clk);
			seen = (host_granted == level);
			cycles++;
		end
		if (!seen) begin
			note_timeout($sformatf("host_granted did not go %b", level), word_limit);
		end
	endtask

	// streams burst_words with host inputs driven on the rising edge
	task automatic stream_host_words(input int count, input word_t first_rx);
		int i;
		int cycles;
		logic seen;
		word_t expect_rx;
		if (!host_enable) begin
			@(posedge serial_clk);
			host_tx_word <= burst_words[0];
			host_enable <= 1'b1;
		end
		for (i = 0; i < count; i++) begin
			cycles = 0;
			seen = 1'b0;
			while (!seen && cycles < word_limit) begin
				@(negedge serial_clk);
				seen = host_next_word;
				cycles++;
			end
			if (!seen) begin
				note_timeout($sformatf("host_next_word for word %0d", i), word_limit);
				return;
			end
			// next word up before word_done or enable dropped after the last
			@(posedge serial_clk);
			if (i + 1 < count) begin
				host_tx_word <= burst_words[i+1];
			end else begin
				host_enable <= 1'b0;
			end
			cycles = 0;
			seen = 1'b0;
			while (!seen && cycles < word_limit) begin
				@(negedge serial_clk);
				seen = host_word_done;
				cycles++;
			end
			if (!seen) begin
				note_timeout($sformatf("host_word_done for word %0d", i), word_limit);
				return;
			end
			if (i == 0) begin
				expect_rx = first_rx;
			end else begin
				expect_rx = burst_words[i-1];
			end
			if (host_rx_word !== expect_rx) begin
				flag_error($sformatf("rx word %0d is %h, expected %h", i, host_rx_word,
					expect_rx));
			end
			@(posedge serial_clk);
			gap_arm = (i + 1 < count);
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic reset_and_check_idle;
		@(negedge serial_clk);
		expect_idle_lines("during reset");
		if (init_done !== 1'b0) begin
			flag_error("init_done high during reset");
		end
		@(posedge serial_clk);
		in_rst <= 1'b0;
		// host asks early and init still goes first
		burst_words[0] = 8'h5a;
		host_tx_word <= burst_words[0];
		host_enable <= 1'b1;
		// first edge out of reset
		@(posedge serial_clk);
		@(negedge serial_clk);
		expect_idle_lines("after reset");
	endtask

	task automatic check_init_table;
		int cycles;
		int i;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < (init_words + 1) * word_cycles) begin
			@(negedge serial_clk);
			seen = init_done;
			cycles++;
		end
		if (!seen) begin
			note_timeout("init_done rising", (init_words + 1) * word_cycles);
			return;
		end
		@(posedge serial_clk);
		if (sdo_words.size() != init_words) begin
			flag_error($sformatf("%0d words before init_done", sdo_words.size()));
		end
		for (i = 0; i < init_words && i < sdo_words.size(); i++) begin
			if (sdo_words[i] !== init_table[i]) begin
				flag_error($sformatf("init word %0d is %h, expected %h", i, sdo_words[i],
					init_table[i]));
			end
		end
		if (done_early || granted_early) begin
			flag_error("init_done or host_granted up before the table went out");
		end
	endtask

	task automatic send_single_host_word;
		wait_for_grant(1'b1);
		if (timeout_count != 0) begin
			return;
		end
		// echo returns the last init word
		stream_host_words(1, init_table[init_words-1]);
		if (timeout_count != 0) begin
			return;
		end
		wait_for_grant(1'b0);
		@(posedge serial_clk);
		if (host_done_cnt != 1 || host_next_cnt != 1 || order_errors != 0) begin
			flag_error($sformatf("strobes next %0d done %0d, order errors %0d",
				host_next_cnt, host_done_cnt, order_errors));
		end
		if (sdo_words.size() != init_words + 1 || sdo_words[init_words] !== burst_words[0]) begin
			flag_error("host word missing or wrong on sdo");
		end
	endtask

	task automatic send_host_burst;
		int i;
		int base_done;
		int base_words;
		word_t prev_word;
		prev_word = burst_words[0];
		for (i = 0; i < 5; i++) begin
			burst_words[i] = word_t'($random(seed));
		end
		@(posedge serial_clk);
		base_done = host_done_cnt;
		base_words = sdo_words.size();
		gap_max = 0;
		gap_falls = 0;
		stream_host_words(5, prev_word);
		if (timeout_count != 0) begin
			return;
		end
		wait_for_grant(1'b0);
		@(posedge serial_clk);
		if (host_done_cnt - base_done != 5 || order_errors != 0) begin
			flag_error($sformatf("%0d word_done pulses in burst, expected 5",
				host_done_cnt - base_done));
		end
		for (i = 0; i < 5 && base_words + i < sdo_words.size(); i++) begin
			if (sdo_words[base_words+i] !== burst_words[i]) begin
				flag_error($sformatf("burst word %0d on sdo is %h, expected %h", i,
					sdo_words[base_words+i], burst_words[i]));
			end
		end
		if (gap_falls == 0 || gap_max > clk_div) begin
			flag_error($sformatf("sclk high for %0d cycles inside the burst", gap_max));
		end
	endtask

	task automatic measure_word_length;
		int i;
		word_t prev_word;
		prev_word = burst_words[4];
		burst_words[0] = 8'hc3;
		burst_words[1] = 8'h96;
		@(posedge serial_clk);
		len_q.delete();
		stream_host_words(2, prev_word);
		if (timeout_count != 0) begin
			return;
		end
		// lines back at idle once enable is down
		for (i = 0; i < 2 * clk_div; i++) begin
			@(negedge serial_clk);
			if (sclk !== sclk_idle || sdo !== sdo_idle) begin
				flag_error("sclk or sdo not idle after enable dropped");
			end
		end
		@(posedge serial_clk);
		if (len_q.size() != 2) begin
			flag_error($sformatf("%0d word lengths measured, expected 2", len_q.size()));
		end
		for (i = 0; i < len_q.size(); i++) begin
			if (len_q[i] != word_cycles) begin
				flag_error($sformatf("word %0d took %0d cycles, expected %0d", i, len_q[i],
					word_cycles));
			end
		end
	endtask

	task automatic finish_run;
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	initial begin
		host_enable = 1'b0;
		host_tx_word = '0;
		seed = 32'ha048;
		reset_and_check_idle();
		check_init_table();
		if (timeout_count == 0) begin
			send_single_host_word();
		end
		if (timeout_count == 0) begin
			send_host_burst();
		end
		if (timeout_count == 0) begin
			measure_word_length();
		end
		finish_run();
	end

endmodule

// File: flist.f
serial_pkg.sv
serial_bus_if.sv
serial_tick_gen.sv
serial_shifter.sv
serial_arbiter.sv
init_sequencer.sv
serial_top.sv
tb_serial.sv

// File: Makefile
# Verilator flow for the 3-wire serial master
TOP := tb_serial
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module serial_top

sim:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
